// ==== logic/mixPkg.sv ====
package mixPkg;

	// sign in bit 30, then bytes 1 to 5 from the top down
	typedef logic [30:0] mixWord;
	typedef logic [29:0] mixMag;
	typedef logic [11:0] mixAddr;

	localparam int MemWords = 4096;
	localparam int ByteBits = 6;

	// one block of the single I/O unit
	localparam int BlockWords = 4;

	// words loaded by the go button after reset
	localparam int BootWords = 64;

	// HLT shares opcode 5 with NUM and CHAR
	localparam logic [5:0] HltField = 6'd2;

	typedef enum logic [5:0] {
		NOP  = 6'd0,
		ADD  = 6'd1,
		SUB  = 6'd2,
		SPEC = 6'd5,
		LDA  = 6'd8,
		LDX  = 6'd15,
		STA  = 6'd24,
		STX  = 6'd31,
		JBUS = 6'd34,
		IOC  = 6'd35,
		IN   = 6'd36,
		OUT  = 6'd37,
		JRED = 6'd38,
		JMP  = 6'd39,
		ADRA = 6'd48,
		CMPA = 6'd56
	} mixOp;

	typedef enum logic [2:0] {
		CORE_IDLE,
		CORE_FETCH,
		CORE_DECODE,
		CORE_OPERAND,
		CORE_EXECUTE,
		CORE_WAITIO,
		CORE_HALTED
	} coreState;

	typedef enum logic [2:0] {
		CHAN_BOOT,
		CHAN_IDLE,
		CHAN_INBLOCK,
		CHAN_OUTREAD,
		CHAN_OUTSEND
	} chanState;

endpackage

// ==== logic/fieldUnit.sv ====
`timescale 1ns/1ps

module fieldUnit import mixPkg::*; (
	input logic [5:0] field,
	input mixWord memWord,
	input mixWord regWord,
	output mixWord extracted,
	output mixWord merged
);
	logic [2:0] left;
	logic [2:0] right;
	logic [2:0] firstByte;
	logic [2:0] byteCount;
	logic [4:0] alignShift;
	mixMag byteMask;
	mixMag placeMask;

	always_comb begin
		left = field[5:3];
		right = field[2:0];
		// malformed spec means the whole word
		if (right > 3'd5 || left > right) begin
			left = 3'd0;
			right = 3'd5;
		end

		// byte 0 is the sign
		firstByte = (left == 3'd0) ? 3'd1 : left;
		byteCount = (right >= firstByte) ? right - firstByte + 3'd1 : 3'd0;
		alignShift = 5'(ByteBits * (5 - int'(right)));

		// a shift of 30 clears everything, so five bytes give all ones
		byteMask = ~({30{1'b1}} << (ByteBits * int'(byteCount)));
		placeMask = byteMask << alignShift;

		extracted[30] = (left == 3'd0) ? memWord[30] : 1'b0;
		extracted[29:0] = (memWord[29:0] >> alignShift) & byteMask;

		// rightmost bytes of the register land in L..R
		merged[30] = (left == 3'd0) ? regWord[30] : memWord[30];
		merged[29:0] = (memWord[29:0] & ~placeMask)
			| ((regWord[29:0] << alignShift) & placeMask);
	end

endmodule

// ==== logic/coreMemory.sv ====
`timescale 1ns/1ps

module coreMemory import mixPkg::*; (
	input logic clk,
	input logic memWe,
	input mixAddr memAddr,
	input mixWord memWdata,
	output mixWord memRdata
);
	mixWord mem [MemWords];

	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[memAddr] <= memWdata;
		end
		// old contents on a write to the same address
		memRdata <= mem[memAddr];
	end

endmodule

// ==== logic/memoryArbiter.sv ====
`timescale 1ns/1ps

module memoryArbiter import mixPkg::*; (
	input logic clk,
	input logic reset,
	input logic coreReq,
	input logic coreWe,
	input mixAddr coreAddr,
	input mixWord coreWdata,
	output logic coreGrant,
	output logic coreRvalid,
	output mixWord coreRdata,
	input logic chanReq,
	input logic chanWe,
	input mixAddr chanAddr,
	input mixWord chanWdata,
	output logic chanGrant,
	output logic chanRvalid,
	output mixWord chanRdata,
	output logic memWe,
	output mixAddr memAddr,
	output mixWord memWdata,
	input mixWord memRdata
);
	// channel always wins, the core retries
	assign chanGrant = chanReq;
	assign coreGrant = coreReq & ~chanReq;

	assign memWe = chanGrant ? chanWe : (coreGrant & coreWe);
	assign memAddr = chanGrant ? chanAddr : coreAddr;
	assign memWdata = chanGrant ? chanWdata : coreWdata;

	// remember who read, the word comes back next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			coreRvalid <= 1'b0;
			chanRvalid <= 1'b0;
		end else begin
			coreRvalid <= coreGrant & ~coreWe;
			chanRvalid <= chanGrant & ~chanWe;
		end
	end

	assign coreRdata = coreRvalid ? memRdata : '0;
	assign chanRdata = chanRvalid ? memRdata : '0;

endmodule

// ==== logic/mixCore.sv ====
`timescale 1ns/1ps

module mixCore import mixPkg::*; (
	input logic clk,
	input logic reset,
	input logic go,
	output logic coreReq,
	output logic coreWe,
	output mixAddr coreAddr,
	output mixWord coreWdata,
	input logic coreGrant,
	input logic coreRvalid,
	input mixWord coreRdata,
	input logic chanBusy,
	output logic ioStart,
	output logic ioOut,
	output mixAddr ioAddr,
	output logic halted
);
	coreState state;
	mixAddr pc;
	mixWord instr;
	mixWord opWord;
	mixWord cmpWord;
	mixWord rA;
	mixWord rX;
	logic overflow;
	logic less;
	logic equal;
	logic greater;
	logic readIssued;

	mixOp op;
	logic [5:0] fieldSpec;
	mixAddr addrM;
	mixWord addrWord;
	mixWord extracted;
	mixWord merged;
	logic isStore;
	logic isIo;
	logic jumpTaken;
	mixWord addend;
	mixWord sum;
	logic carry;
	logic cmpLess;
	logic cmpEqual;
	logic cmpGreater;

	function automatic logic needsOperand(input mixOp code);
		return code inside {ADD, SUB, LDA, LDX, STA, STX, CMPA};
	endfunction

	assign op = mixOp'(instr[5:0]);
	assign fieldSpec = instr[11:6];
	// index byte is always 0, M is the address magnitude
	assign addrM = instr[29:18];
	assign addrWord = {instr[30], 18'd0, instr[29:18]};
	assign isStore = (op == STA) || (op == STX);
	assign isIo = (op == IN) || (op == OUT);

	// while in OPERAND the unit extracts rA(F) for CMPA
	fieldUnit fields (
		.field(fieldSpec),
		.memWord((state == CORE_OPERAND) ? rA : opWord),
		.regWord((op == STX) ? rX : rA),
		.extracted(extracted),
		.merged(merged)
	);

	// sign-magnitude adder shared by ADD, SUB, INCA and DECA
	always_comb begin
		logic [30:0] magSum;
		addend = (op == ADRA) ? addrWord : extracted;
		if (op == SUB || (op == ADRA && fieldSpec == 6'd1)) begin
			addend[30] = ~addend[30];
		end
		magSum = {1'b0, rA[29:0]} + {1'b0, addend[29:0]};
		carry = 1'b0;
		if (rA[30] == addend[30]) begin
			carry = magSum[30];
			sum = {rA[30], magSum[29:0]};
		end else if (rA[29:0] >= addend[29:0]) begin
			// equal magnitudes leave a zero with the sign of rA
			sum = {rA[30], rA[29:0] - addend[29:0]};
		end else begin
			sum = {addend[30], addend[29:0] - rA[29:0]};
		end
	end

	// +0 and -0 compare equal
	always_comb begin
		logic aNeg;
		logic vNeg;
		aNeg = cmpWord[30] && (cmpWord[29:0] != '0);
		vNeg = extracted[30] && (extracted[29:0] != '0);
		cmpEqual = (aNeg == vNeg) && (cmpWord[29:0] == extracted[29:0]);
		if (aNeg != vNeg) begin
			cmpLess = aNeg;
		end else if (aNeg) begin
			cmpLess = cmpWord[29:0] > extracted[29:0];
		end else begin
			cmpLess = cmpWord[29:0] < extracted[29:0];
		end
		cmpGreater = ~cmpLess & ~cmpEqual;
	end

	always_comb begin
		jumpTaken = 1'b0;
		case (op)
			JMP: begin
				case (fieldSpec)
					6'd0, 6'd1: jumpTaken = 1'b1;
					6'd2: jumpTaken = overflow;
					6'd3: jumpTaken = ~overflow;
					6'd4: jumpTaken = less;
					6'd5: jumpTaken = equal;
					6'd6: jumpTaken = greater;
					6'd7: jumpTaken = ~less;
					6'd8: jumpTaken = ~equal;
					6'd9: jumpTaken = ~greater;
					default: jumpTaken = 1'b0;
				endcase
			end
			JBUS: jumpTaken = chanBusy;
			JRED: jumpTaken = ~chanBusy;
			default: jumpTaken = 1'b0;
		endcase
	end

	always_comb begin
		coreReq = 1'b0;
		coreWe = 1'b0;
		coreAddr = addrM;
		coreWdata = merged;
		case (state)
			CORE_FETCH: begin
				coreReq = 1'b1;
				coreAddr = pc;
			end
			CORE_OPERAND: coreReq = ~readIssued;
			// store is a read-modify-write, this is the write half
			CORE_EXECUTE: begin
				coreReq = isStore;
				coreWe = isStore;
			end
			default: coreReq = 1'b0;
		endcase
	end

	assign ioStart = (state == CORE_EXECUTE || state == CORE_WAITIO) && isIo && !chanBusy;
	assign ioOut = (op == OUT);
	assign ioAddr = addrM;
	assign halted = (state == CORE_HALTED);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CORE_IDLE;
			pc <= '0;
			rA <= '0;
			rX <= '0;
			overflow <= 1'b0;
			less <= 1'b0;
			equal <= 1'b0;
			greater <= 1'b0;
			readIssued <= 1'b0;
		end else begin
			case (state)
				CORE_IDLE: begin
					if (go) begin
						state <= CORE_FETCH;
					end
				end
				CORE_FETCH: begin
					if (coreGrant) begin
						state <= CORE_DECODE;
					end
				end
				CORE_DECODE: begin
					if (coreRvalid) begin
						instr <= coreRdata;
						pc <= pc + 1'b1;
						if (needsOperand(mixOp'(coreRdata[5:0]))) begin
							state <= CORE_OPERAND;
						end else begin
							state <= CORE_EXECUTE;
						end
					end
				end
				CORE_OPERAND: begin
					if (!readIssued) begin
						readIssued <= coreGrant;
					end else if (coreRvalid) begin
						readIssued <= 1'b0;
						opWord <= coreRdata;
						cmpWord <= extracted;
						state <= CORE_EXECUTE;
					end
				end
				CORE_EXECUTE: begin
					state <= CORE_FETCH;
					if (jumpTaken) begin
						pc <= addrM;
					end
					case (op)
						ADD, SUB: begin
							rA <= sum;
							overflow <= overflow | carry;
						end
						LDA: rA <= extracted;
						LDX: rX <= extracted;
						STA, STX: begin
							if (!coreGrant) begin
								state <= CORE_EXECUTE;
							end
						end
						ADRA: begin
							case (fieldSpec)
								6'd0, 6'd1: begin
									rA <= sum;
									overflow <= overflow | carry;
								end
								6'd2: rA <= addrWord;
								6'd3: rA <= {~addrWord[30], addrWord[29:0]};
								default: rA <= rA;
							endcase
						end
						CMPA: begin
							less <= cmpLess;
							equal <= cmpEqual;
							greater <= cmpGreater;
						end
						JMP: begin
							if (fieldSpec == 6'd2 || fieldSpec == 6'd3) begin
								overflow <= 1'b0;
							end
						end
						IN, OUT: begin
							if (chanBusy) begin
								state <= CORE_WAITIO;
							end
						end
						SPEC: begin
							if (fieldSpec == HltField) begin
								state <= CORE_HALTED;
							end
						end
						default: state <= CORE_FETCH;
					endcase
				end
				CORE_WAITIO: begin
					if (!chanBusy) begin
						state <= CORE_FETCH;
					end
				end
				CORE_HALTED: state <= CORE_HALTED;
				default: state <= CORE_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/ioChannel.sv ====
`timescale 1ns/1ps

module ioChannel import mixPkg::*; (
	input logic clk,
	input logic reset,
	input mixWord inWord,
	input logic inValid,
	output logic inArmed,
	output mixWord outWord,
	output logic outValid,
	output logic chanReq,
	output logic chanWe,
	output mixAddr chanAddr,
	output mixWord chanWdata,
	input logic chanGrant,
	input logic chanRvalid,
	input mixWord chanRdata,
	input logic ioStart,
	input logic ioOut,
	input mixAddr ioAddr,
	output logic chanBusy,
	output logic go
);
	chanState state;
	logic [$clog2(BootWords)-1:0] count;
	mixAddr addrReg;
	logic pendWrite;
	mixWord pendWord;
	logic accept;
	logic lastWord;
	logic outReturn;

	assign inArmed = (state == CHAN_BOOT) || (state == CHAN_INBLOCK);
	assign accept = inValid && inArmed;
	assign outReturn = (state == CHAN_OUTSEND) && chanRvalid;

	// boot counts a whole image, IN and OUT count one block
	assign lastWord = (state == CHAN_BOOT)
		? (count == ($clog2(BootWords))'(BootWords - 1))
		: (count == ($clog2(BootWords))'(BlockWords - 1));

	// a word still waiting for its store keeps the unit busy
	assign chanBusy = (state == CHAN_INBLOCK) || (state == CHAN_OUTREAD)
		|| (state == CHAN_OUTSEND) || pendWrite;

	// the channel has priority, a store lands the cycle after acceptance
	assign chanReq = pendWrite || (state == CHAN_OUTREAD);
	assign chanWe = pendWrite;
	assign chanAddr = addrReg;
	assign chanWdata = pendWord;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CHAN_BOOT;
			count <= '0;
			addrReg <= '0;
			pendWrite <= 1'b0;
			outValid <= 1'b0;
			go <= 1'b0;
		end else begin
			pendWrite <= accept;
			go <= accept && (state == CHAN_BOOT) && lastWord;
			outValid <= outReturn;
			if (pendWrite) begin
				addrReg <= addrReg + 1'b1;
			end
			case (state)
				CHAN_BOOT, CHAN_INBLOCK: begin
					if (accept) begin
						count <= count + 1'b1;
						if (lastWord) begin
							state <= CHAN_IDLE;
						end
					end
				end
				CHAN_IDLE: begin
					if (ioStart && !chanBusy) begin
						addrReg <= ioAddr;
						count <= '0;
						state <= ioOut ? CHAN_OUTREAD : CHAN_INBLOCK;
					end
				end
				CHAN_OUTREAD: begin
					if (chanGrant) begin
						state <= CHAN_OUTSEND;
					end
				end
				CHAN_OUTSEND: begin
					if (chanRvalid) begin
						addrReg <= addrReg + 1'b1;
						count <= count + 1'b1;
						state <= lastWord ? CHAN_IDLE : CHAN_OUTREAD;
					end
				end
				default: state <= CHAN_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (accept) begin
			pendWord <= inWord;
		end
		if (outReturn) begin
			outWord <= chanRdata;
		end
	end

endmodule

// ==== logic/mixSystem.sv ====
`timescale 1ns/1ps

module mixSystem import mixPkg::*; (
	input logic clk,
	input logic reset,
	input mixWord inWord,
	input logic inValid,
	output logic inArmed,
	output mixWord outWord,
	output logic outValid,
	output logic halted
);
	logic coreReq;
	logic coreWe;
	mixAddr coreAddr;
	mixWord coreWdata;
	logic coreGrant;
	logic coreRvalid;
	mixWord coreRdata;

	logic chanReq;
	logic chanWe;
	mixAddr chanAddr;
	mixWord chanWdata;
	logic chanGrant;
	logic chanRvalid;
	mixWord chanRdata;

	logic memWe;
	mixAddr memAddr;
	mixWord memWdata;
	mixWord memRdata;

	logic chanBusy;
	logic go;
	logic ioStart;
	logic ioOut;
	mixAddr ioAddr;

	mixCore core (
		.clk(clk),
		.reset(reset),
		.go(go),
		.coreReq(coreReq),
		.coreWe(coreWe),
		.coreAddr(coreAddr),
		.coreWdata(coreWdata),
		.coreGrant(coreGrant),
		.coreRvalid(coreRvalid),
		.coreRdata(coreRdata),
		.chanBusy(chanBusy),
		.ioStart(ioStart),
		.ioOut(ioOut),
		.ioAddr(ioAddr),
		.halted(halted)
	);

	ioChannel channel (
		.clk(clk),
		.reset(reset),
		.inWord(inWord),
		.inValid(inValid),
		.inArmed(inArmed),
		.outWord(outWord),
		.outValid(outValid),
		.chanReq(chanReq),
		.chanWe(chanWe),
		.chanAddr(chanAddr),
		.chanWdata(chanWdata),
		.chanGrant(chanGrant),
		.chanRvalid(chanRvalid),
		.chanRdata(chanRdata),
		.ioStart(ioStart),
		.ioOut(ioOut),
		.ioAddr(ioAddr),
		.chanBusy(chanBusy),
		.go(go)
	);

	memoryArbiter arbiter (
		.clk(clk),
		.reset(reset),
		.coreReq(coreReq),
		.coreWe(coreWe),
		.coreAddr(coreAddr),
		.coreWdata(coreWdata),
		.coreGrant(coreGrant),
		.coreRvalid(coreRvalid),
		.coreRdata(coreRdata),
		.chanReq(chanReq),
		.chanWe(chanWe),
		.chanAddr(chanAddr),
		.chanWdata(chanWdata),
		.chanGrant(chanGrant),
		.chanRvalid(chanRvalid),
		.chanRdata(chanRdata),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata)
	);

	coreMemory memory (
		.clk(clk),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata)
	);

endmodule

// ==== tb/mixSystem_checker.sv ====
`timescale 1ns/1ps

module mixSystemChecker (
	input logic clk,
	input logic reset,
	input logic coreGrant,
	input logic chanGrant,
	input logic coreWe,
	input logic chanWe,
	input logic coreRvalid,
	input logic chanRvalid,
	input logic outValid,
	input logic halted,
	input logic go
);
	logic goSeen;

	always_ff @(posedge clk) begin
		if (reset) begin
			goSeen <= 1'b0;
		end else if (go) begin
			goSeen <= 1'b1;
		end
	end

	grantsExclusive: assert property (@(posedge clk) disable iff (reset)
		!(coreGrant && chanGrant)) else $error("both memory grants high");

	coreReadReturns: assert property (@(posedge clk) disable iff (reset)
		(coreGrant && !coreWe) |=> coreRvalid) else $error("core read without Rvalid");

	chanReadReturns: assert property (@(posedge clk) disable iff (reset)
		(chanGrant && !chanWe) |=> chanRvalid) else $error("channel read without Rvalid");

	quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
		$rose(outValid) |-> !halted) else $error("outValid after halt");

	singleGo: assert property (@(posedge clk) disable iff (reset)
		go |-> !goSeen) else $error("second go pulse");

endmodule

bind mixSystem mixSystemChecker sysChecker (
	.clk(clk),
	.reset(reset),
	.coreGrant(coreGrant),
	.chanGrant(chanGrant),
	.coreWe(coreWe),
	.chanWe(chanWe),
	.coreRvalid(coreRvalid),
	.chanRvalid(chanRvalid),
	.outValid(outValid),
	.halted(halted),
	.go(go)
);

// ==== tb/mixModel.svh ====
`ifndef MIX_MODEL_SVH
`define MIX_MODEL_SVH

// byte b of a word, 1 is the leftmost
function automatic int byteOf(mixWord w, int b);
	return int'((w[29:0] >> (6 * (5 - b))) & 30'h3f);
endfunction

function automatic void fieldBounds(int spec, output int l, output int r);
	l = spec / 8;
	r = spec % 8;
	if (r > 5 || l > r) begin
		l = 0;
		r = 5;
	end
endfunction

function automatic mixWord fieldOf(int spec, mixWord w);
	int l;
	int r;
	mixWord v;
	fieldBounds(spec, l, r);
	v = '0;
	for (int b = (l == 0) ? 1 : l; b <= r; b++) begin
		v[29:0] = (v[29:0] << 6) | 30'(byteOf(w, b));
	end
	v[30] = (l == 0) ? w[30] : 1'b0;
	return v;
endfunction

function automatic mixWord mergeInto(int spec, mixWord dst, mixWord src);
	int l;
	int r;
	int shift;
	mixWord res;
	fieldBounds(spec, l, r);
	res = dst;
	if (l == 0) begin
		res[30] = src[30];
	end
	// byte R gets byte 5 of the register, R-1 gets byte 4 and so on
	for (int b = r; b >= ((l == 0) ? 1 : l); b--) begin
		shift = 6 * (5 - b);
		res[29:0] = (res[29:0] & ~(30'h3f << shift))
			| (30'(byteOf(src, 5 - (r - b))) << shift);
	end
	return res;
endfunction

function automatic mixWord addSigned(mixWord a, mixWord b, output logic carry);
	logic [30:0] total;
	carry = 1'b0;
	if (a[30] == b[30]) begin
		total = {1'b0, a[29:0]} + {1'b0, b[29:0]};
		carry = total[30];
		return {a[30], total[29:0]};
	end
	// a zero difference keeps the sign of the left operand
	if (a[29:0] >= b[29:0]) begin
		return {a[30], a[29:0] - b[29:0]};
	end
	return {b[30], b[29:0] - a[29:0]};
endfunction

function automatic longint signedValue(mixWord w);
	return w[30] ? -longint'(w[29:0]) : longint'(w[29:0]);
endfunction

function automatic logic jumpCond(int f, logic ov, logic lt, logic eq, logic gt);
	case (f)
		0, 1: return 1'b1;
		2: return ov;
		3: return ~ov;
		4: return lt;
		5: return eq;
		6: return gt;
		7: return ~lt;
		8: return ~eq;
		9: return ~gt;
		default: return 1'b0;
	endcase
endfunction

// instruction level run of the boot image, fills expOut
task automatic runModel();
	mixAddr pc;
	mixWord ins;
	mixWord rA;
	mixWord rX;
	mixWord v;
	mixWord addrW;
	logic ov;
	logic carry;
	logic lt;
	logic eq;
	logic gt;
	logic take;
	logic [5:0] op;
	int f;
	int m;
	int inPos;
	for (int i = 0; i < BootWords; i++) begin
		modelMem[i] = image[i];
	end
	expOut = {};
	pc = '0;
	rA = '0;
	rX = '0;
	ov = 1'b0;
	lt = 1'b0;
	eq = 1'b0;
	gt = 1'b0;
	inPos = 0;
	for (int steps = 0; steps < 2000; steps++) begin
		ins = modelMem[pc];
		pc = pc + 1'b1;
		op = ins[5:0];
		f = int'(ins[11:6]);
		m = int'(ins[29:18]);
		addrW = {ins[30], 18'd0, ins[29:18]};
		take = 1'b0;
		case (op)
			ADD, SUB: begin
				v = fieldOf(f, modelMem[m]);
				if (op == SUB) begin
					v[30] = ~v[30];
				end
				rA = addSigned(rA, v, carry);
				ov = ov | carry;
			end
			LDA: rA = fieldOf(f, modelMem[m]);
			LDX: rX = fieldOf(f, modelMem[m]);
			STA: modelMem[m] = mergeInto(f, modelMem[m], rA);
			STX: modelMem[m] = mergeInto(f, modelMem[m], rX);
			IN: begin
				for (int k = 0; k < BlockWords; k++) begin
					modelMem[m + k] = inData[inPos];
					inPos++;
				end
			end
			OUT: begin
				for (int k = 0; k < BlockWords; k++) begin
					expOut.push_back(modelMem[m + k]);
				end
			end
			// the unit is idle whenever the program tests it
			JRED: take = 1'b1;
			JMP: begin
				take = jumpCond(f, ov, lt, eq, gt);
				if (f == 2 || f == 3) begin
					ov = 1'b0;
				end
			end
			ADRA: begin
				if (f == 1) begin
					addrW[30] = ~addrW[30];
				end
				if (f <= 1) begin
					rA = addSigned(rA, addrW, carry);
					ov = ov | carry;
				end else if (f == 2) begin
					rA = addrW;
				end else if (f == 3) begin
					rA = {~addrW[30], addrW[29:0]};
				end
			end
			CMPA: begin
				lt = signedValue(fieldOf(f, rA)) < signedValue(fieldOf(f, modelMem[m]));
				eq = signedValue(fieldOf(f, rA)) == signedValue(fieldOf(f, modelMem[m]));
				gt = ~lt & ~eq;
			end
			SPEC: begin
				if (f == int'(HltField)) begin
					return;
				end
			end
			default: take = 1'b0;
		endcase
		if (take) begin
			pc = mixAddr'(m);
		end
	end
endtask

`endif

// ==== tb/mixSystemTb.sv ====
`timescale 1ns/1ps

module mixSystemTb import mixPkg::*; ();
	localparam int Programs = 24;
	localparam int CycleLimit = Programs * 3000;

	logic clk;
	logic reset;
	mixWord inWord;
	logic inValid;
	logic inArmed;
	mixWord outWord;
	logic outValid;
	logic halted;

	int unsigned seed = 38929;
	int cycles;
	int outCount;
	mixWord image [BootWords];
	mixWord modelMem [MemWords];
	mixWord inData [$];
	mixWord expOut [$];

	mixSystem dut (
		.clk(clk),
		.reset(reset),
		.inWord(inWord),
		.inValid(inValid),
		.inArmed(inArmed),
		.outWord(outWord),
		.outValid(outValid),
		.halted(halted)
	);

	function automatic int unsigned lcg();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic int randRange(int n);
		return int'((lcg() >> 16) % n);
	endfunction

	// sometimes a signed zero or a small value, mostly a full word
	function automatic mixWord randData();
		int unsigned r1;
		int unsigned r2;
		r1 = lcg();
		r2 = lcg();
		case (randRange(8))
			0: return {r1[31], 30'd0};
			1: return {r1[31], 24'd0, r2[31:26]};
			default: return {r1[31], r1[31:17], r2[31:17]};
		endcase
	endfunction

	function automatic int randSpec();
		return 8 * randRange(6) + randRange(6);
	endfunction

	function automatic mixWord encode(mixOp op, int f, int m, logic s);
		return {s, 12'(m), 6'd0, 6'(f), op};
	endfunction

	`include "mixModel.svh"

	task automatic failRun(string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(string name, mixWord expected, mixWord actual);
		if (actual !== expected) begin
			failRun($sformatf("Error at %0t: %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkHalted(logic expected, logic actual);
		if (actual !== expected) begin
			failRun($sformatf("Error at %0t: halted expected %b actual %b",
				$time, expected, actual));
		end
	endtask

	task automatic checkArmed(logic expected, logic actual);
		if (actual !== expected) begin
			failRun($sformatf("Error at %0t: inArmed expected %b actual %b",
				$time, expected, actual));
		end
	endtask

	// code from templates at 0..39, data at 40..63
	task automatic buildProgram();
		int pos;
		int p;
		int mA;
		int mB;
		inData = {};
		for (int a = 0; a < BootWords; a++) begin
			image[a] = (a < 40) ? '0 : randData();
		end
		pos = 0;
		while (pos <= 30) begin
			p = pos;
			mA = 40 + randRange(21);
			mB = 40 + randRange(21);
			case (randRange(5))
				0: begin
					image[p] = encode(OUT, 0, randRange(61), 1'b0);
					image[p + 1] = encode(JBUS, 0, p + 1, 1'b0);
					pos = p + 2;
				end
				1: begin
					image[p] = encode(randRange(2) ? LDA : LDX, randSpec(), 40 + randRange(24), 1'b0);
					image[p + 1] = encode(randRange(2) ? STA : STX, randSpec(), mA, 1'b0);
					image[p + 2] = encode(OUT, 0, mA, 1'b0);
					image[p + 3] = encode(JBUS, 0, p + 3, 1'b0);
					pos = p + 4;
				end
				2: begin
					image[p] = encode(LDA, 5, 40 + randRange(24), 1'b0);
					image[p + 1] = encode(randRange(2) ? ADD : SUB, randSpec(), 40 + randRange(24), 1'b0);
					image[p + 2] = encode(STA, 5, mA, 1'b0);
					image[p + 3] = encode(JMP, 2 + randRange(2), p + 6, 1'b0);
					image[p + 4] = encode(OUT, 0, mA, 1'b0);
					image[p + 5] = encode(JBUS, 0, p + 5, 1'b0);
					image[p + 6] = encode(OUT, 0, mB, 1'b0);
					image[p + 7] = encode(JBUS, 0, p + 7, 1'b0);
					pos = p + 8;
				end
				3: begin
					image[p] = encode(ADRA, randRange(4), randRange(4) ? randRange(64) : 0,
						1'(randRange(2)));
					image[p + 1] = encode(ADRA, randRange(2), randRange(4) ? randRange(64) : 0,
						1'(randRange(2)));
					image[p + 2] = encode(CMPA, randRange(2) ? 5 : randSpec(), 40 + randRange(24), 1'b0);
					image[p + 3] = encode(JMP, randRange(10), p + 6, 1'b0);
					image[p + 4] = encode(OUT, 0, mA, 1'b0);
					image[p + 5] = encode(JBUS, 0, p + 5, 1'b0);
					image[p + 6] = encode(OUT, 0, mB, 1'b0);
					image[p + 7] = encode(JBUS, 0, p + 7, 1'b0);
					pos = p + 8;
				end
				default: begin
					image[p] = encode(IN, 0, mA, 1'b0);
					image[p + 1] = encode(JBUS, 0, p + 1, 1'b0);
					image[p + 2] = encode(OUT, 0, mA, 1'b0);
					image[p + 3] = encode(JBUS, 0, p + 3, 1'b0);
					for (int k = 0; k < BlockWords; k++) begin
						inData.push_back(randData());
					end
					pos = p + 4;
				end
			endcase
		end
		image[pos] = encode(SPEC, int'(HltField), 0, 1'b0);
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		inValid <= 1'b0;
		repeat (8) @(posedge clk);
		outCount = 0;
		reset <= 1'b0;
		@(negedge clk);
		checkHalted(1'b0, halted);
		checkArmed(1'b1, inArmed);
	endtask

	// boot image first, then the IN blocks in program order
	task automatic feedWords();
		mixWord words [$];
		int fed;
		logic blockDone;
		words = {};
		fed = 0;
		foreach (image[i]) begin
			words.push_back(image[i]);
		end
		foreach (inData[i]) begin
			words.push_back(inData[i]);
		end
		while (words.size() > 0) begin
			@(negedge clk);
			if (inArmed) begin
				@(posedge clk);
				inWord <= words.pop_front();
				inValid <= 1'b1;
				@(posedge clk);
				inValid <= 1'b0;
				fed++;
				// the boot image and every IN block end with the channel disarmed
				blockDone = (fed == BootWords)
					|| (fed > BootWords && (fed - BootWords) % BlockWords == 0);
				@(negedge clk);
				checkArmed(!blockDone, inArmed);
				repeat (randRange(4)) @(posedge clk);
			end
		end
	endtask

	task automatic waitHalted();
		while (!halted) begin
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CycleLimit) begin
			failRun("timeout, the programs did not finish within the cycle limit");
		end
	end

	always @(negedge clk) begin
		if (!reset && outValid) begin
			if (outCount >= expOut.size()) begin
				failRun("an OUT word appeared that the model does not predict");
			end else begin
				checkHalted(1'b0, halted);
				checkWord("outWord", expOut[outCount], outWord);
				outCount++;
			end
		end
	end

	initial begin
		reset <= 1'b1;
		inValid <= 1'b0;
		inWord <= '0;
		cycles = 0;
		outCount = 0;
		for (int prog = 0; prog < Programs; prog++) begin
			buildProgram();
			runModel();
			applyReset();
			fork
				feedWords();
				waitHalted();
			join
			// halted must hold and no more words may come out
			repeat (20) @(negedge clk);
			checkHalted(1'b1, halted);
			if (outCount != expOut.size()) begin
				failRun($sformatf("Error at %0t: OUT word count expected %0d actual %0d",
					$time, expOut.size(), outCount));
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== mixSystem.f ====
+incdir+tb
logic/mixPkg.sv
logic/fieldUnit.sv
logic/coreMemory.sv
logic/memoryArbiter.sv
logic/mixCore.sv
logic/ioChannel.sv
logic/mixSystem.sv
tb/mixSystem_checker.sv
tb/mixSystemTb.sv

// ==== Makefile ====
TOP = mixSystemTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mixSystem.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir
